//--- logic/periph_defs.svh
// Cluster peripheral parameters.
// Core and counter counts, data widths and the register map offsets.

`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

`define PERIPH_NR_CORES      4
`define PERIPH_NUM_PERF_CNT  4
`define PERIPH_PERF_CNT_W    48
`define PERIPH_ADDR_W        8
`define PERIPH_DATA_W        64

// Byte offsets, one 64-bit word per register.
`define PERIPH_OFS_CNT_EN       8'h00
`define PERIPH_OFS_CNT_SEL      8'h08
`define PERIPH_OFS_CNT          8'h28
`define PERIPH_OFS_CLINT_SET    8'h48
`define PERIPH_OFS_CLINT_CLEAR  8'h50
`define PERIPH_OFS_PREFETCH     8'h58

`endif

//--- logic/periph_reg_pkg.sv
// Cluster peripheral register map types.
// Request and response words, decoded access and the write-data views.

`include "periph_defs.svh"

package periph_reg_pkg;

  typedef struct packed {
    logic                      valid;
    logic                      write;
    logic [`PERIPH_ADDR_W-1:0] addr;
    logic [`PERIPH_DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic                      valid;
    logic [`PERIPH_DATA_W-1:0] rdata;
    logic                      error;
  } reg_rsp_t;

  typedef enum logic [2:0] {
    CNT_EN,
    CNT_SEL,
    CNT,
    CLINT_SET,
    CLINT_CLEAR,
    PREFETCH,
    NONE
  } reg_region_e;

  // Counter select register layout.
  typedef struct packed {
    logic [47:0] reserved;
    logic [7:0]  hart;
    logic [7:0]  metric;
  } perf_sel_t;

  typedef union packed {
    logic [`PERIPH_DATA_W-1:0] raw;
    perf_sel_t                 sel;
  } reg_wdata_u;

  typedef struct packed {
    logic        valid;
    logic        write;
    reg_region_e region;
    logic [1:0]  index;
    reg_wdata_u  wdata;
    logic        error;
  } reg_access_t;

endpackage

//--- logic/cluster_event_pkg.sv
// Cluster event types.
// Per-core, TCDM and instruction-cache event strobes and the metric codes.

package cluster_event_pkg;

  typedef struct packed {
    logic retired_instr;
    logic retired_load;
    logic issue_fpu;
  } core_events_t;

  typedef struct packed {
    logic inc_accessed;
    logic inc_congested;
  } tcdm_events_t;

  typedef struct packed {
    logic l0_miss;
    logic l0_hit;
    logic l0_prefetch;
    logic l0_stall;
  } icache_events_t;

  typedef enum logic [7:0] {
    CYCLE           = 8'd0,
    RETIRED_INSTR   = 8'd1,
    RETIRED_LOAD    = 8'd2,
    ISSUE_FPU       = 8'd3,
    TCDM_ACCESSED   = 8'd4,
    TCDM_CONGESTED  = 8'd5,
    ICACHE_MISS     = 8'd6,
    ICACHE_HIT      = 8'd7,
    ICACHE_PREFETCH = 8'd8,
    ICACHE_STALL    = 8'd9
  } perf_metric_e;

endpackage

//--- logic/periph_reg_decode.sv
// Register decode for the cluster peripheral.
// Maps request addresses to regions and holds the enable, CLINT and prefetch registers.

`timescale 1ns/1ps

`include "periph_defs.svh"

module periph_reg_decode (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  periph_reg_pkg::reg_req_t          reg_req_i,
  output periph_reg_pkg::reg_access_t       access_o,
  output logic [`PERIPH_NUM_PERF_CNT-1:0]   cnt_en_o,
  output logic [31:0]                       clint_o,
  output logic                              prefetch_en_o
);

  logic [`PERIPH_ADDR_W-1:0]       addr;
  logic [`PERIPH_ADDR_W-1:0]       ofs_sel;
  logic [`PERIPH_ADDR_W-1:0]       ofs_cnt;
  logic [`PERIPH_NUM_PERF_CNT-1:0] cnt_en_q;
  logic [31:0]                     clint_q;
  logic                            prefetch_q;

  assign addr    = reg_req_i.addr;
  assign ofs_sel = addr - `PERIPH_OFS_CNT_SEL;
  assign ofs_cnt = addr - `PERIPH_OFS_CNT;

  always_comb begin
    access_o.valid  = reg_req_i.valid;
    access_o.write  = reg_req_i.write;
    access_o.wdata  = reg_req_i.wdata;
    access_o.region = periph_reg_pkg::NONE;
    access_o.index  = 2'd0;
    // Only whole-word aligned addresses map to a register.
    if (addr[2:0] == 3'b000) begin
      if (addr == `PERIPH_OFS_CNT_EN) begin
        access_o.region = periph_reg_pkg::CNT_EN;
      end else if (addr >= `PERIPH_OFS_CNT_SEL &&
                   addr < `PERIPH_OFS_CNT_SEL + 8 * `PERIPH_NUM_PERF_CNT) begin
        access_o.region = periph_reg_pkg::CNT_SEL;
        access_o.index  = ofs_sel[4:3];
      end else if (addr >= `PERIPH_OFS_CNT &&
                   addr < `PERIPH_OFS_CNT + 8 * `PERIPH_NUM_PERF_CNT) begin
        access_o.region = periph_reg_pkg::CNT;
        access_o.index  = ofs_cnt[4:3];
      end else if (addr == `PERIPH_OFS_CLINT_SET) begin
        access_o.region = periph_reg_pkg::CLINT_SET;
      end else if (addr == `PERIPH_OFS_CLINT_CLEAR) begin
        access_o.region = periph_reg_pkg::CLINT_CLEAR;
      end else if (addr == `PERIPH_OFS_PREFETCH) begin
        access_o.region = periph_reg_pkg::PREFETCH;
      end
    end
    access_o.error = (access_o.region == periph_reg_pkg::NONE);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_en_q   <= '1;
      clint_q    <= '0;
      prefetch_q <= 1'b1;
    end else if (access_o.valid && access_o.write) begin
      case (access_o.region)
        periph_reg_pkg::CNT_EN:      cnt_en_q   <= access_o.wdata.raw[`PERIPH_NUM_PERF_CNT-1:0];
        periph_reg_pkg::CLINT_SET:   clint_q    <= clint_q | access_o.wdata.raw[31:0];
        periph_reg_pkg::CLINT_CLEAR: clint_q    <= clint_q & ~access_o.wdata.raw[31:0];
        periph_reg_pkg::PREFETCH:    prefetch_q <= access_o.wdata.raw[0];
        default: ;
      endcase
    end
  end

  assign cnt_en_o      = cnt_en_q;
  assign clint_o       = clint_q;
  assign prefetch_en_o = prefetch_q;

endmodule

//--- logic/perf_counter_bank.sv
// Performance counter bank.
// Per-counter metric and hart selection, event pipelining and 48-bit counting.

`timescale 1ns/1ps

`include "periph_defs.svh"

module perf_counter_bank (
  input  logic                                                   clk_i,
  input  logic                                                   rst_i,
  input  periph_reg_pkg::reg_access_t                            access_i,
  input  logic [`PERIPH_NUM_PERF_CNT-1:0]                        cnt_en_i,
  input  cluster_event_pkg::core_events_t   [`PERIPH_NR_CORES-1:0] core_events_i,
  input  cluster_event_pkg::tcdm_events_t                        tcdm_events_i,
  input  cluster_event_pkg::icache_events_t [`PERIPH_NR_CORES-1:0] icache_events_i,
  output logic [`PERIPH_NUM_PERF_CNT-1:0][`PERIPH_PERF_CNT_W-1:0] cnt_o,
  output periph_reg_pkg::perf_sel_t [`PERIPH_NUM_PERF_CNT-1:0]   sel_o
);

  localparam int unsigned hart_w = $clog2(`PERIPH_NR_CORES);

  // Metrics tracked straight out of reset.
  localparam cluster_event_pkg::perf_metric_e [`PERIPH_NUM_PERF_CNT-1:0] rst_metric = {
    cluster_event_pkg::ICACHE_MISS,
    cluster_event_pkg::TCDM_ACCESSED,
    cluster_event_pkg::RETIRED_INSTR,
    cluster_event_pkg::CYCLE
  };

  cluster_event_pkg::tcdm_events_t                          tcdm_q;
  cluster_event_pkg::icache_events_t [`PERIPH_NR_CORES-1:0] icache_q;

  logic [`PERIPH_NUM_PERF_CNT-1:0][`PERIPH_PERF_CNT_W-1:0] cnt_q;
  cluster_event_pkg::perf_metric_e [`PERIPH_NUM_PERF_CNT-1:0] metric_q;
  logic [`PERIPH_NUM_PERF_CNT-1:0][hart_w-1:0]            hart_q;

  logic [`PERIPH_NUM_PERF_CNT-1:0] inc;
  logic [`PERIPH_NUM_PERF_CNT-1:0] cnt_wr;
  logic [`PERIPH_NUM_PERF_CNT-1:0] sel_wr;

  // Register accesses aimed at a single counter.
  always_comb begin
    for (int i = 0; i < `PERIPH_NUM_PERF_CNT; i++) begin
      cnt_wr[i] = access_i.valid && access_i.write && (access_i.index == i[1:0]) &&
                  (access_i.region == periph_reg_pkg::CNT);
      sel_wr[i] = access_i.valid && access_i.write && (access_i.index == i[1:0]) &&
                  (access_i.region == periph_reg_pkg::CNT_SEL);
    end
  end

  // Core events are used as they arrive, TCDM and icache events one cycle late.
  always_comb begin
    for (int i = 0; i < `PERIPH_NUM_PERF_CNT; i++) begin
      case (metric_q[i])
        cluster_event_pkg::CYCLE:           inc[i] = 1'b1;
        cluster_event_pkg::RETIRED_INSTR:   inc[i] = core_events_i[hart_q[i]].retired_instr;
        cluster_event_pkg::RETIRED_LOAD:    inc[i] = core_events_i[hart_q[i]].retired_load;
        cluster_event_pkg::ISSUE_FPU:       inc[i] = core_events_i[hart_q[i]].issue_fpu;
        cluster_event_pkg::TCDM_ACCESSED:   inc[i] = tcdm_q.inc_accessed;
        cluster_event_pkg::TCDM_CONGESTED:  inc[i] = tcdm_q.inc_congested;
        cluster_event_pkg::ICACHE_MISS:     inc[i] = icache_q[hart_q[i]].l0_miss;
        cluster_event_pkg::ICACHE_HIT:      inc[i] = icache_q[hart_q[i]].l0_hit;
        cluster_event_pkg::ICACHE_PREFETCH: inc[i] = icache_q[hart_q[i]].l0_prefetch;
        cluster_event_pkg::ICACHE_STALL:    inc[i] = icache_q[hart_q[i]].l0_stall;
        default:                            inc[i] = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tcdm_q   <= '0;
      icache_q <= '0;
      cnt_q    <= '0;
      metric_q <= rst_metric;
      hart_q   <= '0;
    end else begin
      tcdm_q   <= tcdm_events_i;
      icache_q <= icache_events_i;
      for (int i = 0; i < `PERIPH_NUM_PERF_CNT; i++) begin
        // A counter write wins over that cycle's increment.
        if (cnt_wr[i]) begin
          cnt_q[i] <= '0;
        end else if (cnt_en_i[i]) begin
          cnt_q[i] <= cnt_q[i] + `PERIPH_PERF_CNT_W'(inc[i]);
        end
        if (sel_wr[i]) begin
          metric_q[i] <= cluster_event_pkg::perf_metric_e'(access_i.wdata.sel.metric);
          hart_q[i]   <= access_i.wdata.sel.hart[hart_w-1:0];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `PERIPH_NUM_PERF_CNT; i++) begin
      sel_o[i].reserved = '0;
      sel_o[i].hart     = 8'(hart_q[i]);
      sel_o[i].metric   = metric_q[i];
    end
  end

  assign cnt_o = cnt_q;

endmodule

//--- logic/periph_readback.sv
// Register readback for the cluster peripheral.
// Selects read data by region and returns a registered one-cycle response.

`timescale 1ns/1ps

`include "periph_defs.svh"

module periph_readback (
  input  logic                                                   clk_i,
  input  logic                                                   rst_i,
  input  periph_reg_pkg::reg_access_t                            access_i,
  input  logic [`PERIPH_NUM_PERF_CNT-1:0][`PERIPH_PERF_CNT_W-1:0] cnt_i,
  input  periph_reg_pkg::perf_sel_t [`PERIPH_NUM_PERF_CNT-1:0]   sel_i,
  input  logic [`PERIPH_NUM_PERF_CNT-1:0]                        cnt_en_i,
  input  logic                                                   prefetch_en_i,
  output periph_reg_pkg::reg_rsp_t                               reg_rsp_o
);

  logic [`PERIPH_DATA_W-1:0] rdata;
  logic [`PERIPH_DATA_W-1:0] rdata_q;
  logic                      valid_q;
  logic                      error_q;

  // CLINT set and clear read as zero, as does anything unmapped.
  always_comb begin
    case (access_i.region)
      periph_reg_pkg::CNT_EN:   rdata = `PERIPH_DATA_W'(cnt_en_i);
      periph_reg_pkg::CNT_SEL:  rdata = sel_i[access_i.index];
      periph_reg_pkg::CNT:      rdata = `PERIPH_DATA_W'(cnt_i[access_i.index]);
      periph_reg_pkg::PREFETCH: rdata = `PERIPH_DATA_W'(prefetch_en_i);
      default:                  rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      valid_q <= access_i.valid;
      error_q <= access_i.valid && access_i.error;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access_i.valid) begin
      rdata_q <= rdata;
    end
  end

  assign reg_rsp_o.valid = valid_q;
  assign reg_rsp_o.rdata = rdata_q;
  assign reg_rsp_o.error = error_q;

endmodule

//--- logic/cluster_periph_top.sv
// Cluster peripheral top level.
// Register decode, performance counter bank and register readback.

`timescale 1ns/1ps

`include "periph_defs.svh"

module cluster_periph_top (
  input  logic                                                   clk_i,
  input  logic                                                   rst_i,
  input  periph_reg_pkg::reg_req_t                               reg_req_i,
  output periph_reg_pkg::reg_rsp_t                               reg_rsp_o,
  input  cluster_event_pkg::core_events_t   [`PERIPH_NR_CORES-1:0] core_events_i,
  input  cluster_event_pkg::tcdm_events_t                        tcdm_events_i,
  input  cluster_event_pkg::icache_events_t [`PERIPH_NR_CORES-1:0] icache_events_i,
  output logic [`PERIPH_NR_CORES-1:0]                            cl_clint_o,
  output logic                                                   icache_prefetch_enable_o
);

  periph_reg_pkg::reg_access_t                             access;
  logic [`PERIPH_NUM_PERF_CNT-1:0]                         cnt_en;
  logic [31:0]                                             clint;
  logic [`PERIPH_NUM_PERF_CNT-1:0][`PERIPH_PERF_CNT_W-1:0] cnt;
  periph_reg_pkg::perf_sel_t [`PERIPH_NUM_PERF_CNT-1:0]    sel;

  periph_reg_decode periph_reg_decode_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .reg_req_i     (reg_req_i),
    .access_o      (access),
    .cnt_en_o      (cnt_en),
    .clint_o       (clint),
    .prefetch_en_o (icache_prefetch_enable_o)
  );

  perf_counter_bank perf_counter_bank_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .access_i        (access),
    .cnt_en_i        (cnt_en),
    .core_events_i   (core_events_i),
    .tcdm_events_i   (tcdm_events_i),
    .icache_events_i (icache_events_i),
    .cnt_o           (cnt),
    .sel_o           (sel)
  );

  periph_readback periph_readback_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .access_i      (access),
    .cnt_i         (cnt),
    .sel_i         (sel),
    .cnt_en_i      (cnt_en),
    .prefetch_en_i (icache_prefetch_enable_o),
    .reg_rsp_o     (reg_rsp_o)
  );

  // One wake-up bit per core.
  assign cl_clint_o = clint[`PERIPH_NR_CORES-1:0];

endmodule

//--- verification/cluster_periph_tb.sv
// Testbench for the cluster peripheral.
// Runs a table of register accesses and event traffic against a behavioral model.

`timescale 1ns/1ps

`include "periph_defs.svh"

module cluster_periph_tb;

  localparam logic [1:0] OP_WRITE = 2'd0;
  localparam logic [1:0] OP_READ = 2'd1;
  localparam logic [1:0] OP_IDLE = 2'd2;
  localparam int RSP_TIMEOUT = 16;

  typedef struct packed {
    logic [1:0]                op;
    logic [`PERIPH_ADDR_W-1:0] addr;
    logic [`PERIPH_DATA_W-1:0] data;
    logic                      ev;
    logic [`PERIPH_DATA_W-1:0] exp_rdata;
    logic                      exp_err;
  } test_entry_t;

  logic                                                    clk;
  logic                                                    rst;
  periph_reg_pkg::reg_req_t                                reg_req;
  periph_reg_pkg::reg_rsp_t                                reg_rsp;
  cluster_event_pkg::core_events_t   [`PERIPH_NR_CORES-1:0] core_events;
  cluster_event_pkg::tcdm_events_t                         tcdm_events;
  cluster_event_pkg::icache_events_t [`PERIPH_NR_CORES-1:0] icache_events;
  logic [`PERIPH_NR_CORES-1:0]                             cl_clint;
  logic                                                    prefetch_en;

  test_entry_t tests[$];
  string       names[$];
  integer      seed;
  int          errors;
  int          timeouts;

  // Model state, advanced once per rising edge.
  logic [`PERIPH_NUM_PERF_CNT-1:0][`PERIPH_PERF_CNT_W-1:0] m_cnt;
  logic [`PERIPH_NUM_PERF_CNT-1:0][7:0]                    m_metric;
  logic [`PERIPH_NUM_PERF_CNT-1:0][1:0]                    m_hart;
  logic [`PERIPH_NUM_PERF_CNT-1:0]                         m_en;
  logic [31:0]                                             m_clint;
  logic                                                    m_prefetch;
  cluster_event_pkg::tcdm_events_t                         m_tcdm_q;
  cluster_event_pkg::icache_events_t [`PERIPH_NR_CORES-1:0] m_icache_q;

  cluster_periph_top cluster_periph_top_inst (
    .clk_i                    (clk),
    .rst_i                    (rst),
    .reg_req_i                (reg_req),
    .reg_rsp_o                (reg_rsp),
    .core_events_i            (core_events),
    .tcdm_events_i            (tcdm_events),
    .icache_events_i          (icache_events),
    .cl_clint_o               (cl_clint),
    .icache_prefetch_enable_o (prefetch_en)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic add_test(input string name, input logic [1:0] op, input logic [7:0] addr,
                          input logic [63:0] data, input logic ev);
    test_entry_t t;
    t = '0;
    t.op = op;
    t.addr = addr;
    t.data = data;
    t.ev = ev;
    tests.push_back(t);
    names.push_back(name);
  endtask

  // The register map is one contiguous run of words from 0x00 to the prefetch word.
  function automatic logic mapped(input logic [7:0] addr);
    return (addr[2:0] == 3'b000) && (addr <= `PERIPH_OFS_PREFETCH);
  endfunction

  // Select and counter blocks both start one word into a 32-byte group.
  function automatic logic [63:0] read_value(input logic [7:0] addr);
    logic [1:0] idx;
    idx = addr[4:3] - 2'd1;
    if (!mapped(addr)) return '0;
    if (addr == `PERIPH_OFS_CNT_EN) return {60'd0, m_en};
    if (addr < `PERIPH_OFS_CNT) return {48'd0, 6'd0, m_hart[idx], m_metric[idx]};
    if (addr < `PERIPH_OFS_CLINT_SET) return {16'd0, m_cnt[idx]};
    if (addr == `PERIPH_OFS_PREFETCH) return {63'd0, m_prefetch};
    return '0;
  endfunction

  function automatic logic event_hit(input logic [7:0] metric, input logic [1:0] hart,
      input cluster_event_pkg::core_events_t [`PERIPH_NR_CORES-1:0] core_ev);
    case (metric)
      8'd0: return 1'b1;
      8'd1: return core_ev[hart].retired_instr;
      8'd2: return core_ev[hart].retired_load;
      8'd3: return core_ev[hart].issue_fpu;
      8'd4: return m_tcdm_q.inc_accessed;
      8'd5: return m_tcdm_q.inc_congested;
      8'd6: return m_icache_q[hart].l0_miss;
      8'd7: return m_icache_q[hart].l0_hit;
      8'd8: return m_icache_q[hart].l0_prefetch;
      8'd9: return m_icache_q[hart].l0_stall;
      default: return 1'b0;
    endcase
  endfunction

  // Drives one cycle of inputs and steps the model across the following edge.
  task automatic drive_cycle(input periph_reg_pkg::reg_req_t req, input logic ev,
                             output logic [63:0] exp_rdata, output logic exp_err);
    logic [31:0] rnd;
    logic [1:0]  idx;
    logic        wr;
    rnd = ev ? $random(seed) : 32'd0;
    reg_req = req;
    core_events = rnd[11:0];
    tcdm_events = rnd[13:12];
    icache_events = rnd[29:14];
    exp_rdata = read_value(req.addr);
    exp_err = req.valid && !mapped(req.addr);
    wr = req.valid && req.write && mapped(req.addr);
    idx = req.addr[4:3] - 2'd1;
    for (int i = 0; i < `PERIPH_NUM_PERF_CNT; i++) begin
      if (wr && req.addr >= `PERIPH_OFS_CNT && req.addr < `PERIPH_OFS_CLINT_SET &&
          idx == i[1:0]) begin
        m_cnt[i] = '0;
      end else if (m_en[i]) begin
        m_cnt[i] = m_cnt[i] + {47'd0, event_hit(m_metric[i], m_hart[i], rnd[11:0])};
      end
    end
    if (wr) begin
      if (req.addr == `PERIPH_OFS_CNT_EN) begin
        m_en = req.wdata[3:0];
      end else if (req.addr < `PERIPH_OFS_CNT) begin
        m_metric[idx] = req.wdata[7:0];
        m_hart[idx] = req.wdata[9:8];
      end else if (req.addr == `PERIPH_OFS_CLINT_SET) begin
        m_clint = m_clint | req.wdata[31:0];
      end else if (req.addr == `PERIPH_OFS_CLINT_CLEAR) begin
        m_clint = m_clint & ~req.wdata[31:0];
      end else if (req.addr == `PERIPH_OFS_PREFETCH) begin
        m_prefetch = req.wdata[0];
      end
    end
    m_tcdm_q = rnd[13:12];
    m_icache_q = rnd[29:14];
  endtask

  task automatic fill_tests();
    add_test("rst_cnt_en", OP_READ, 8'h00, 64'h0, 1'b0);
    add_test("rst_sel0", OP_READ, 8'h08, 64'h0, 1'b1);
    add_test("rst_sel1", OP_READ, 8'h10, 64'h0, 1'b1);
    add_test("rst_sel2", OP_READ, 8'h18, 64'h0, 1'b1);
    add_test("rst_sel3", OP_READ, 8'h20, 64'h0, 1'b1);
    add_test("rst_prefetch", OP_READ, 8'h58, 64'h0, 1'b1);
    add_test("run_events", OP_IDLE, 8'h00, 64'd12, 1'b1);
    add_test("rst_cycle", OP_READ, 8'h28, 64'h0, 1'b1);
    add_test("rst_instr", OP_READ, 8'h30, 64'h0, 1'b1);
    add_test("rst_tcdm", OP_READ, 8'h38, 64'h0, 1'b1);
    add_test("rst_imiss", OP_READ, 8'h40, 64'h0, 1'b1);
    add_test("clint_set", OP_WRITE, 8'h48, 64'h5, 1'b1);
    add_test("clint_set_rd", OP_READ, 8'h48, 64'h0, 1'b1);
    add_test("clint_clr", OP_WRITE, 8'h50, 64'h1, 1'b1);
    add_test("clint_clr_rd", OP_READ, 8'h50, 64'h0, 1'b1);
    add_test("sel1_fpu", OP_WRITE, 8'h10, 64'h0203, 1'b1);
    add_test("cnt1_clr", OP_WRITE, 8'h30, 64'h0, 1'b1);
    add_test("fpu_events", OP_IDLE, 8'h00, 64'd16, 1'b1);
    add_test("cnt1_fpu", OP_READ, 8'h30, 64'h0, 1'b1);
    add_test("sel2_stall", OP_WRITE, 8'h18, 64'h0509, 1'b1);
    add_test("sel2_rd", OP_READ, 8'h18, 64'h0, 1'b1);
    add_test("cnt2_clr", OP_WRITE, 8'h38, 64'h0, 1'b1);
    add_test("stall_events", OP_IDLE, 8'h00, 64'd16, 1'b1);
    add_test("cnt2_stall", OP_READ, 8'h38, 64'h0, 1'b1);
    add_test("sel3_cong", OP_WRITE, 8'h20, 64'h0005, 1'b1);
    add_test("cnt3_clr", OP_WRITE, 8'h40, 64'h0, 1'b1);
    add_test("cong_events", OP_IDLE, 8'h00, 64'd10, 1'b1);
    add_test("cnt3_cong", OP_READ, 8'h40, 64'h0, 1'b1);
    add_test("en_mask", OP_WRITE, 8'h00, 64'hd, 1'b1);
    add_test("masked_events", OP_IDLE, 8'h00, 64'd10, 1'b1);
    add_test("cnt1_frozen", OP_READ, 8'h30, 64'h0, 1'b1);
    add_test("cnt0_running", OP_READ, 8'h28, 64'h0, 1'b1);
    add_test("en_all", OP_WRITE, 8'h00, 64'hf, 1'b1);
    add_test("pf_off", OP_WRITE, 8'h58, 64'h0, 1'b1);
    add_test("pf_rd", OP_READ, 8'h58, 64'h0, 1'b1);
    add_test("pf_on", OP_WRITE, 8'h58, 64'h1, 1'b1);
    add_test("err_unmapped", OP_READ, 8'h60, 64'h0, 1'b1);
    add_test("err_unaligned", OP_READ, 8'h0c, 64'h0, 1'b1);
    add_test("err_write", OP_WRITE, 8'hf8, '1, 1'b1);
  endtask

  initial begin
    logic [63:0]              exp_rdata;
    logic                     exp_err;
    logic                     got;
    int                       lat;
    periph_reg_pkg::reg_req_t req;
    periph_reg_pkg::reg_req_t idle_req;
    seed = 90;
    errors = 0;
    timeouts = 0;
    rst = 1'b1;
    reg_req = '0;
    core_events = '0;
    tcdm_events = '0;
    icache_events = '0;
    m_cnt = '0;
    m_metric = {8'd6, 8'd4, 8'd1, 8'd0};
    m_hart = '0;
    m_en = '1;
    m_clint = '0;
    m_prefetch = 1'b1;
    m_tcdm_q = '0;
    m_icache_q = '0;
    idle_req = '0;
    fill_tests();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < tests.size(); n++) begin
      if (tests[n].op == OP_IDLE) begin
        for (int c = 0; c < int'(tests[n].data); c++) begin
          drive_cycle(idle_req, tests[n].ev, exp_rdata, exp_err);
          @(negedge clk);
          if (reg_rsp.valid) begin
            $display("Test %s: response seen without a request", names[n]);
            errors++;
          end
        end
      end else begin
        req.valid = 1'b1;
        req.write = (tests[n].op == OP_WRITE);
        req.addr = tests[n].addr;
        req.wdata = tests[n].data;
        drive_cycle(req, tests[n].ev, exp_rdata, exp_err);
        tests[n].exp_rdata = exp_rdata;
        tests[n].exp_err = exp_err;
        got = 1'b0;
        lat = 0;
        for (int t = 0; t < RSP_TIMEOUT && !got; t++) begin
          @(negedge clk);
          if (reg_rsp.valid) begin
            got = 1'b1;
            lat = t + 1;
          end else begin
            drive_cycle(idle_req, tests[n].ev, exp_rdata, exp_err);
          end
        end
        if (!got) begin
          $display("Test %s: no response within %0d cycles", names[n], RSP_TIMEOUT);
          timeouts++;
        end else begin
          // The response belongs in the cycle right after the request.
          if (lat != 1) begin
            $display("Test %s: response came %0d cycles after the request instead of 1",
                     names[n], lat);
            errors++;
          end
          if (reg_rsp.rdata !== tests[n].exp_rdata) begin
            $display("MISMATCH %s rdata: expected %h, actual %h", names[n],
                     tests[n].exp_rdata, reg_rsp.rdata);
            errors++;
          end
          if (reg_rsp.error !== tests[n].exp_err) begin
            $display("MISMATCH %s error: expected %b, actual %b", names[n],
                     tests[n].exp_err, reg_rsp.error);
            errors++;
          end
          if (cl_clint !== m_clint[`PERIPH_NR_CORES-1:0]) begin
            $display("MISMATCH %s cl_clint: expected %h, actual %h", names[n],
                     m_clint[`PERIPH_NR_CORES-1:0], cl_clint);
            errors++;
          end
          if (prefetch_en !== m_prefetch) begin
            $display("MISMATCH %s prefetch: expected %b, actual %b", names[n],
                     m_prefetch, prefetch_en);
            errors++;
          end
        end
      end
    end
    reg_req = '0;
    $display("Summary: %0d failed checks, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- cluster_periph.f
+incdir+logic
logic/periph_reg_pkg.sv
logic/cluster_event_pkg.sv
logic/periph_reg_decode.sv
logic/perf_counter_bank.sv
logic/periph_readback.sv
logic/cluster_periph_top.sv
verification/cluster_periph_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = cluster_periph_tb
FILELIST = cluster_periph.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
